/* project.f */
logic/vsense_pkg.sv
logic/color_threshold.sv
logic/frame_capture.sv
logic/blob_locator.sv
logic/frame_store_arbiter.sv
logic/frame_ram.sv
logic/video_sensor_top.sv
verif/video_sensor_checker.sv
verif/tb_video_sensor.sv

/* Bender.yml */
package:
  name: video_sensor

sources:
  - logic/vsense_pkg.sv
  - logic/color_threshold.sv
  - logic/frame_capture.sv
  - logic/blob_locator.sv
  - logic/frame_store_arbiter.sv
  - logic/frame_ram.sv
  - logic/video_sensor_top.sv
  - target: test
    files:
      - verif/video_sensor_checker.sv
      - verif/tb_video_sensor.sv

/* verif/tb_video_sensor.sv */
// Video sensor testbench
`timescale 1ns/100ps
`default_nettype none

module tb_video_sensor;

   localparam int IMG_WIDTH       = 16;
   localparam int IMG_HEIGHT      = 12;
   localparam int PIXELS          = IMG_WIDTH * IMG_HEIGHT;
   localparam int ADDR_W          = $clog2(PIXELS);
   localparam int CW              = vsense_pkg::CHAN_W;
   localparam int N_FRAMES        = 5;
   localparam int POST_READS      = 16;    // Host reads after each frame
   localparam int READ_LIMIT      = 20;    // Cycles one host read may take
   localparam int CLK_PERIOD      = 40;
   localparam int WATCHDOG_CYCLES = N_FRAMES * PIXELS * 4 + 1000;
   localparam logic [31:0] LFSR_SEED = 32'h2e35;
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

   // DUT ports
   logic clock_50, arst_n, pixel_valid, capture_start, rd_req, rd_valid;
   logic capture_busy, frame_done;
   vsense_pkg::chan_t pixel_red, pixel_green, pixel_blue;
   vsense_pkg::chan_t red_min, red_max, green_min, green_max, blue_min, blue_max;
   logic [ADDR_W-1:0] rd_addr;
   vsense_pkg::pix_word_t rd_data;
   logic [vsense_pkg::CNT_W-1:0] frame_count, hit_count;
   vsense_pkg::coord_t bbox_x_min, bbox_x_max, bbox_y_min, bbox_y_max;

   // Model state and expectations
   vsense_pkg::pix_word_t ref_mem [PIXELS];     // Frame memory image
   vsense_pkg::pix_word_t frame_pix [PIXELS];   // Frame being sent
   logic [31:0] lfsr;
   logic frame_end, rd_busy;
   int driven, reads_done, rd_wait, tb_errors, error_count, check_count;
   logic [vsense_pkg::CNT_W-1:0] exp_frame_count, exp_hit_count;
   vsense_pkg::coord_t exp_x_min, exp_x_max, exp_y_min, exp_y_max;
   vsense_pkg::pix_word_t exp_rd_data;

   video_sensor_top #(.IMG_WIDTH(IMG_WIDTH), .IMG_HEIGHT(IMG_HEIGHT)) i_dut (
      .clock_50, .arst_n, .pixel_valid, .pixel_red, .pixel_green, .pixel_blue,
      .capture_start, .red_min, .red_max, .green_min, .green_max, .blue_min, .blue_max,
      .rd_req, .rd_addr, .rd_valid, .rd_data, .capture_busy, .frame_done, .frame_count,
      .bbox_x_min, .bbox_x_max, .bbox_y_min, .bbox_y_max, .hit_count
   );

   video_sensor_checker #(.ADDR_W(ADDR_W)) i_checker (
      .clock_50, .arst_n, .capture_busy, .frame_done, .frame_count, .bbox_x_min,
      .bbox_x_max, .bbox_y_min, .bbox_y_max, .hit_count, .rd_valid, .rd_data, .rd_req,
      .rd_addr, .frame_end, .exp_frame_count, .exp_x_min, .exp_x_max, .exp_y_min,
      .exp_y_max, .exp_hit_count, .exp_rd_data, .error_count, .check_count
   );

   always #(CLK_PERIOD / 2) clock_50 = ~clock_50;

   // Galois LFSR, one step per bit
   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] v;
      int          i;
      v = '0;
      for (i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   // Inclusive window on all three channels
   function automatic logic window_hit(input vsense_pkg::pix_word_t p);
      vsense_pkg::chan_t r;
      vsense_pkg::chan_t g;
      vsense_pkg::chan_t b;
      r = p[3*CW-1:2*CW];
      g = p[2*CW-1:CW];
      b = p[CW-1:0];
      return (r >= red_min) && (r <= red_max) && (g >= green_min) && (g <= green_max) &&
             (b >= blue_min) && (b <= blue_max);
   endfunction

   task automatic predict_frame();
      int                           i;
      vsense_pkg::coord_t           x;
      vsense_pkg::coord_t           y;
      logic [vsense_pkg::CNT_W-1:0] hits;
      hits = '0;
      {exp_x_min, exp_x_max, exp_y_min, exp_y_max} = '0;   // Stays zero without hits
      for (i = 0; i < PIXELS; i++) begin
         if (window_hit(frame_pix[i])) begin
            x = vsense_pkg::coord_t'(i % IMG_WIDTH);
            y = vsense_pkg::coord_t'(i / IMG_WIDTH);
            if (hits == '0) begin
               {exp_x_min, exp_x_max, exp_y_min, exp_y_max} = {x, x, y, y};
            end else begin
               if (x < exp_x_min) exp_x_min = x;
               if (x > exp_x_max) exp_x_max = x;
               if (y < exp_y_min) exp_y_min = y;
               if (y > exp_y_max) exp_y_max = y;
            end
            hits = hits + 1'b1;
         end
      end
      exp_hit_count = hits;
   endtask

   // One cycle of stimulus, plus the host read engine
   task automatic tick(input logic pv, input vsense_pkg::pix_word_t px, input logic start,
                       input logic last, input int safe_cnt);
      logic [31:0] pick;
      @(posedge clock_50);
      #2;
      pixel_valid   = pv;
      {pixel_red, pixel_green, pixel_blue} = px;
      capture_start = start;
      frame_end     = last;
      rd_req        = 1'b0;
      if (rd_busy) begin
         if (rd_valid === 1'b1) begin
            rd_busy = 1'b0;
            reads_done++;
         end else if (rd_wait >= READ_LIMIT) begin
            $display("Host read of address %0d got no rd_valid within %0d cycles",
                     rd_addr, READ_LIMIT);
            tb_errors++;
            rd_busy = 1'b0;
         end else begin
            rd_wait++;
         end
      end else if (safe_cnt > 0 && random_bits(2) == 32'd0) begin
         pick        = random_bits(ADDR_W) % safe_cnt;   // Only addresses already written
         rd_req      = 1'b1;
         rd_addr     = pick[ADDR_W-1:0];
         exp_rd_data = ref_mem[pick];
         rd_busy     = 1'b1;
         rd_wait     = 0;
      end
   endtask

   task automatic idle_cycle(input int safe_cnt);
      logic                  pv;
      vsense_pkg::pix_word_t px;
      pv = (random_bits(2) != 32'd0);
      px = vsense_pkg::pix_word_t'(random_bits(3 * CW));
      tick(pv, px, 1'b0, 1'b0, safe_cnt);
   endtask

   // ------------------------------------------------------------
   // One frame: window, stray pixels, capture, done, host reads
   // ------------------------------------------------------------
   task automatic run_frame(input int mode);
      int   i;
      int   a;
      int   b;
      int   waited;
      int   target;
      logic pv;
      logic start;
      for (i = 0; i < PIXELS; i++) begin
         frame_pix[i] = vsense_pkg::pix_word_t'(random_bits(3 * CW));
      end
      {green_min, blue_min} = '0;
      {green_max, blue_max} = '1;
      case (mode)
         1: begin   // Red level zero only, which no pixel carries
            red_min = 8'h00;
            red_max = 8'h00;
            for (i = 0; i < PIXELS; i++) begin
               if (frame_pix[i][3*CW-1:2*CW] == 8'h00) frame_pix[i][3*CW-1:2*CW] = 8'h01;
            end
         end
         2: begin   // Window closed on one value, placed twice
            a = random_bits(ADDR_W) % PIXELS;
            b = random_bits(ADDR_W) % PIXELS;
            frame_pix[b] = frame_pix[a];
            {red_min, green_min, blue_min} = frame_pix[a];
            {red_max, green_max, blue_max} = frame_pix[a];
         end
         4: begin
            red_min = 8'h00;
            red_max = 8'hff;
         end
         default: begin
            red_min   = vsense_pkg::chan_t'(random_bits(6));
            red_max   = 8'd160 + vsense_pkg::chan_t'(random_bits(6));
            green_min = vsense_pkg::chan_t'(random_bits(6));
            green_max = 8'd160 + vsense_pkg::chan_t'(random_bits(6));
            blue_min  = vsense_pkg::chan_t'(random_bits(6));
            blue_max  = 8'd160 + vsense_pkg::chan_t'(random_bits(6));
         end
      endcase
      predict_frame();

      waited = 2 + random_bits(3);
      for (i = 0; i < waited; i++) begin
         idle_cycle(0);   // Ignored, capture not armed
      end

      driven = 0;
      start  = 1'b1;
      while (driven < PIXELS) begin
         pv = (random_bits(2) != 32'd0);
         if (pv) begin
            ref_mem[driven] = frame_pix[driven];
            if (driven == PIXELS - 1) exp_frame_count = exp_frame_count + 1'b1;
         end
         tick(pv, frame_pix[driven], start, pv && (driven == PIXELS - 1),
              (driven > 2) ? driven - 2 : 0);
         if (pv) driven++;
         start = (random_bits(5) == 32'd0);   // Stray start mid frame
      end

      waited = 0;
      while (frame_done !== 1'b1 && waited < 8) begin
         idle_cycle(PIXELS - 2);
         waited++;
      end
      if (frame_done !== 1'b1) begin
         $display("frame_done never arrived for frame %0d", mode);
         tb_errors++;
      end

      target = reads_done + POST_READS;
      waited = 0;
      while ((reads_done < target || rd_busy) && waited < POST_READS * 30) begin
         idle_cycle(PIXELS);
         waited++;
      end
   endtask

   initial begin
      int f;
      lfsr            = LFSR_SEED;
      clock_50        = 1'b0;
      arst_n          = 1'b0;
      pixel_valid     = 1'b0;
      {pixel_red, pixel_green, pixel_blue} = '0;
      capture_start   = 1'b0;
      {red_min, green_min, blue_min} = '0;
      {red_max, green_max, blue_max} = '1;
      rd_req          = 1'b0;
      rd_addr         = '0;
      rd_busy         = 1'b0;
      frame_end       = 1'b0;
      {driven, reads_done, rd_wait, tb_errors} = '0;
      exp_frame_count = '0;
      exp_hit_count   = '0;
      {exp_x_min, exp_x_max, exp_y_min, exp_y_max} = '0;
      exp_rd_data     = '0;
      repeat (8) @(posedge clock_50);
      #2;
      arst_n = 1'b1;
      repeat (3) idle_cycle(0);
      for (f = 0; f < N_FRAMES; f++) begin
         run_frame(f);
      end
      repeat (4) idle_cycle(0);
      $display("Checks %0d, checker errors %0d, testbench errors %0d, host reads %0d",
               check_count, error_count, tb_errors, reads_done);
      if (error_count == 0 && tb_errors == 0 && check_count > 0 && reads_done > 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
      $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

/* verif/video_sensor_checker.sv */
// Video sensor result checker
`timescale 1ns/100ps
`default_nettype none

module video_sensor_checker #(
   parameter int ADDR_W = 8
) (
   input  wire                          clock_50,
   input  wire                          arst_n,
   // DUT outputs
   input  wire                          capture_busy,
   input  wire                          frame_done,
   input  wire [vsense_pkg::CNT_W-1:0]  frame_count,
   input  wire vsense_pkg::coord_t      bbox_x_min,
   input  wire vsense_pkg::coord_t      bbox_x_max,
   input  wire vsense_pkg::coord_t      bbox_y_min,
   input  wire vsense_pkg::coord_t      bbox_y_max,
   input  wire [vsense_pkg::CNT_W-1:0]  hit_count,
   input  wire                          rd_valid,
   input  wire vsense_pkg::pix_word_t   rd_data,
   // Host requests as driven into the DUT
   input  wire                          rd_req,
   input  wire [ADDR_W-1:0]             rd_addr,
   // Model expectations
   input  wire                          frame_end,
   input  wire [vsense_pkg::CNT_W-1:0]  exp_frame_count,
   input  wire vsense_pkg::coord_t      exp_x_min,
   input  wire vsense_pkg::coord_t      exp_x_max,
   input  wire vsense_pkg::coord_t      exp_y_min,
   input  wire vsense_pkg::coord_t      exp_y_max,
   input  wire [vsense_pkg::CNT_W-1:0]  exp_hit_count,
   input  wire vsense_pkg::pix_word_t   exp_rd_data,
   output int                           error_count,
   output int                           check_count
);

   int                    errors;
   int                    checks;
   logic [2:0]            end_pipe;    // Last pixel strobe, three cycles deep
   logic                  rd_open;     // Host read in flight
   logic [ADDR_W-1:0]     rd_addr_q;
   vsense_pkg::pix_word_t rd_exp_q;
   logic                  reset_seen;

   assign error_count = errors;
   assign check_count = checks;

   initial begin
      errors = 0;
      checks = 0;
   end

   task automatic compare_field(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
      end
   endtask

   task automatic note_failure(input string what);
      errors++;
      $display("%0t %s", $time, what);
   endtask

   // ------------------------------------------------------------
   // Sampled on the rising edge, all DUT outputs are registered
   // ------------------------------------------------------------
   always @(posedge clock_50) begin
      if (!arst_n) begin
         end_pipe   = '0;
         rd_open    = 1'b0;
         reset_seen = 1'b0;
      end else begin
         if (!reset_seen) begin   // First edge out of reset
            compare_field("capture_busy", 0, capture_busy);
            compare_field("frame_done", 0, frame_done);
            compare_field("frame_count", 0, frame_count);
            compare_field("hit_count", 0, hit_count);
            compare_field("bbox_x_min", 0, bbox_x_min);
            compare_field("bbox_x_max", 0, bbox_x_max);
            compare_field("bbox_y_min", 0, bbox_y_min);
            compare_field("bbox_y_max", 0, bbox_y_max);
            compare_field("rd_valid", 0, rd_valid);
            reset_seen = 1'b1;
         end

         // Still capturing while the last pixel goes in
         if (frame_end === 1'b1) begin
            compare_field("capture_busy", 1, capture_busy);
         end

         // Done strobe three cycles after the last pixel
         if (frame_done !== 1'b0 || end_pipe[2]) begin
            compare_field("frame_done", end_pipe[2], frame_done);
         end
         if (end_pipe[2]) begin
            compare_field("bbox_x_min", exp_x_min, bbox_x_min);
            compare_field("bbox_x_max", exp_x_max, bbox_x_max);
            compare_field("bbox_y_min", exp_y_min, bbox_y_min);
            compare_field("bbox_y_max", exp_y_max, bbox_y_max);
            compare_field("hit_count", exp_hit_count, hit_count);
            compare_field("frame_count", exp_frame_count, frame_count);
            compare_field("capture_busy", 0, capture_busy);   // Back to idle
         end
         end_pipe = {end_pipe[1:0], frame_end};

         // Host read port
         if (rd_valid === 1'b1) begin
            if (rd_open) begin
               compare_field($sformatf("rd_data[%0d]", rd_addr_q), rd_exp_q, rd_data);
            end else begin
               note_failure("rd_valid came without an outstanding host read");
            end
            rd_open = 1'b0;
         end
         if (rd_req === 1'b1) begin
            if (rd_open) begin
               note_failure("rd_req was issued while a host read was outstanding");
            end
            rd_open   = 1'b1;
            rd_addr_q = rd_addr;
            rd_exp_q  = exp_rd_data;
         end
      end
   end

endmodule

`default_nettype wire

/* logic/video_sensor_top.sv */
// Video sensor capture core
`timescale 1ns/100ps
`default_nettype none

module video_sensor_top #(
   parameter  int IMG_WIDTH  = 16,
   parameter  int IMG_HEIGHT = 12,
   localparam int DEPTH      = IMG_WIDTH * IMG_HEIGHT,
   localparam int ADDR_W     = $clog2(DEPTH)
) (
   input  wire                          clock_50,
   input  wire                          arst_n,
   // Pixel stream
   input  wire                          pixel_valid,
   input  wire vsense_pkg::chan_t       pixel_red,
   input  wire vsense_pkg::chan_t       pixel_green,
   input  wire vsense_pkg::chan_t       pixel_blue,
   input  wire                          capture_start,
   // Threshold window
   input  wire vsense_pkg::chan_t       red_min,
   input  wire vsense_pkg::chan_t       red_max,
   input  wire vsense_pkg::chan_t       green_min,
   input  wire vsense_pkg::chan_t       green_max,
   input  wire vsense_pkg::chan_t       blue_min,
   input  wire vsense_pkg::chan_t       blue_max,
   // Host read port
   input  wire                          rd_req,
   input  wire [ADDR_W-1:0]             rd_addr,
   output logic                         rd_valid,
   output vsense_pkg::pix_word_t        rd_data,
   // Status and results
   output logic                         capture_busy,
   output logic                         frame_done,
   output logic [vsense_pkg::CNT_W-1:0] frame_count,
   output vsense_pkg::coord_t           bbox_x_min,
   output vsense_pkg::coord_t           bbox_x_max,
   output vsense_pkg::coord_t           bbox_y_min,
   output vsense_pkg::coord_t           bbox_y_max,
   output logic [vsense_pkg::CNT_W-1:0] hit_count
);

   // Threshold to capture
   logic                  thr_valid;
   logic                  thr_hit;
   vsense_pkg::pix_word_t thr_pixel;

   // Capture to locator and arbiter
   logic                  hit_valid, frame_first, frame_last;
   vsense_pkg::coord_t    hit_x, hit_y;
   logic                  wr_en;
   logic [ADDR_W-1:0]     wr_addr;
   vsense_pkg::pix_word_t wr_data;

   // Arbiter to memory
   logic                  mem_en, mem_we;
   logic [ADDR_W-1:0]     mem_addr;
   vsense_pkg::pix_word_t mem_wdata, mem_rdata;

   // ------------------------------------------------------------
   // Pixel pipeline
   // ------------------------------------------------------------
   color_threshold i_threshold (
      .clock_50, .arst_n, .pixel_valid, .pixel_red, .pixel_green, .pixel_blue,
      .red_min, .red_max, .green_min, .green_max, .blue_min, .blue_max,
      .thr_valid, .thr_pixel, .thr_hit
   );

   frame_capture #(.IMG_WIDTH(IMG_WIDTH), .IMG_HEIGHT(IMG_HEIGHT)) i_capture (
      .clock_50, .arst_n, .capture_start, .thr_valid, .thr_hit, .thr_pixel,
      .capture_busy, .wr_en, .wr_addr, .wr_data, .hit_valid, .frame_first,
      .frame_last, .frame_done, .hit_x, .hit_y, .frame_count
   );

   blob_locator #(.IMG_WIDTH(IMG_WIDTH), .IMG_HEIGHT(IMG_HEIGHT)) i_locator (
      .clock_50, .arst_n, .hit_valid, .frame_first, .frame_last, .hit_x, .hit_y,
      .bbox_x_min, .bbox_x_max, .bbox_y_min, .bbox_y_max, .hit_count
   );

   // ------------------------------------------------------------
   // Frame memory and its arbiter
   // ------------------------------------------------------------
   frame_store_arbiter #(.DEPTH(DEPTH)) i_arbiter (
      .clock_50, .arst_n, .wr_en, .wr_addr, .wr_data, .rd_req, .rd_addr,
      .mem_rdata, .mem_en, .mem_we, .mem_addr, .mem_wdata, .rd_valid, .rd_data
   );

   frame_ram #(.DEPTH(DEPTH)) i_ram (
      .clock_50, .mem_en, .mem_we, .mem_addr, .mem_wdata, .mem_rdata
   );

endmodule

`default_nettype wire

/* logic/frame_ram.sv */
// Single port frame memory
`timescale 1ns/100ps
`default_nettype none

module frame_ram #(
   parameter  int DEPTH  = 192,
   localparam int ADDR_W = $clog2(DEPTH)
) (
   input  wire                         clock_50,
   input  wire                         mem_en,
   input  wire                         mem_we,
   input  wire [ADDR_W-1:0]            mem_addr,
   input  wire vsense_pkg::pix_word_t  mem_wdata,
   output vsense_pkg::pix_word_t       mem_rdata
);

   vsense_pkg::pix_word_t mem [DEPTH];

   // Registered read, output holds between reads
   always_ff @(posedge clock_50) begin
      if (mem_en) begin
         if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
         end else begin
            mem_rdata <= mem[mem_addr];
         end
      end
   end

endmodule

`default_nettype wire

/* logic/frame_store_arbiter.sv */
// Frame memory arbiter
`timescale 1ns/100ps
`default_nettype none

module frame_store_arbiter #(
   parameter  int DEPTH  = 192,
   localparam int ADDR_W = $clog2(DEPTH)
) (
   input  wire                         clock_50,
   input  wire                         arst_n,
   input  wire                         wr_en,
   input  wire [ADDR_W-1:0]            wr_addr,
   input  wire vsense_pkg::pix_word_t  wr_data,
   input  wire                         rd_req,
   input  wire [ADDR_W-1:0]            rd_addr,
   input  wire vsense_pkg::pix_word_t  mem_rdata,
   output logic                        mem_en,
   output logic                        mem_we,
   output logic [ADDR_W-1:0]           mem_addr,
   output vsense_pkg::pix_word_t       mem_wdata,
   output logic                        rd_valid,
   output vsense_pkg::pix_word_t       rd_data
);

   vsense_pkg::mem_owner_e owner;     // This cycle
   vsense_pkg::mem_owner_e owner_q;   // Previous cycle, lines up with mem_rdata
   logic                   pend_q;
   logic [ADDR_W-1:0]      pend_addr;
   logic [ADDR_W-1:0]      rd_sel;

   assign rd_sel = pend_q ? pend_addr : rd_addr;

   // ------------------------------------------------------------
   // Writer first, then the pending or fresh read
   // ------------------------------------------------------------
   always_comb begin
      if (wr_en) begin
         owner = vsense_pkg::OWN_WRITE;
      end else if (rd_req || pend_q) begin
         owner = vsense_pkg::OWN_READ;
      end else begin
         owner = vsense_pkg::OWN_NONE;
      end
   end

   assign mem_en    = (owner != vsense_pkg::OWN_NONE);
   assign mem_we    = (owner == vsense_pkg::OWN_WRITE);
   assign mem_addr  = (owner == vsense_pkg::OWN_WRITE) ? wr_addr : rd_sel;
   assign mem_wdata = wr_data;

   always_ff @(posedge clock_50 or negedge arst_n) begin
      if (!arst_n) begin
         pend_q  <= 1'b0;
         owner_q <= vsense_pkg::OWN_NONE;
      end else begin
         owner_q <= owner;
         if (owner == vsense_pkg::OWN_READ) begin
            pend_q <= 1'b0;      // Read granted
         end else if (rd_req) begin
            pend_q <= 1'b1;      // Blocked by a write
         end
      end
   end

   always_ff @(posedge clock_50) begin
      if (rd_req) begin
         pend_addr <= rd_addr;
      end
   end

   // Data comes back one cycle after the grant
   assign rd_valid = (owner_q == vsense_pkg::OWN_READ);
   assign rd_data  = mem_rdata;

   // Only one host read may be outstanding
   assert property (@(posedge clock_50) disable iff (!arst_n)
      pend_q |-> !rd_req);

endmodule

`default_nettype wire

/* logic/blob_locator.sv */
// Bounding box locator
`timescale 1ns/100ps
`default_nettype none

module blob_locator #(
   parameter int IMG_WIDTH  = 16,
   parameter int IMG_HEIGHT = 12
) (
   input  wire                          clock_50,
   input  wire                          arst_n,
   input  wire                          hit_valid,
   input  wire                          frame_first,
   input  wire                          frame_last,
   input  wire vsense_pkg::coord_t      hit_x,
   input  wire vsense_pkg::coord_t      hit_y,
   output vsense_pkg::coord_t           bbox_x_min,
   output vsense_pkg::coord_t           bbox_x_max,
   output vsense_pkg::coord_t           bbox_y_min,
   output vsense_pkg::coord_t           bbox_y_max,
   output logic [vsense_pkg::CNT_W-1:0] hit_count
);

   // Empty box starts inverted so the first hit sets both edges
   localparam vsense_pkg::coord_t X_INIT = vsense_pkg::coord_t'(IMG_WIDTH - 1);
   localparam vsense_pkg::coord_t Y_INIT = vsense_pkg::coord_t'(IMG_HEIGHT - 1);

   vsense_pkg::coord_t x_min_q, x_max_q, y_min_q, y_max_q;   // Running box
   vsense_pkg::coord_t x_min_b, x_max_b, y_min_b, y_max_b;   // Base for this pixel
   vsense_pkg::coord_t x_min_n, x_max_n, y_min_n, y_max_n;   // After this pixel
   logic [vsense_pkg::CNT_W-1:0] cnt_q, cnt_b, cnt_n;

   always_comb begin
      if (frame_first) begin   // Restart at the first pixel
         x_min_b = X_INIT;
         x_max_b = '0;
         y_min_b = Y_INIT;
         y_max_b = '0;
         cnt_b   = '0;
      end else begin
         x_min_b = x_min_q;
         x_max_b = x_max_q;
         y_min_b = y_min_q;
         y_max_b = y_max_q;
         cnt_b   = cnt_q;
      end
      x_min_n = (hit_valid && (hit_x < x_min_b)) ? hit_x : x_min_b;
      x_max_n = (hit_valid && (hit_x > x_max_b)) ? hit_x : x_max_b;
      y_min_n = (hit_valid && (hit_y < y_min_b)) ? hit_y : y_min_b;
      y_max_n = (hit_valid && (hit_y > y_max_b)) ? hit_y : y_max_b;
      cnt_n   = hit_valid ? cnt_b + 1'b1 : cnt_b;
   end

   always_ff @(posedge clock_50 or negedge arst_n) begin
      if (!arst_n) begin
         x_min_q    <= X_INIT;
         x_max_q    <= '0;
         y_min_q    <= Y_INIT;
         y_max_q    <= '0;
         cnt_q      <= '0;
         bbox_x_min <= '0;
         bbox_x_max <= '0;
         bbox_y_min <= '0;
         bbox_y_max <= '0;
         hit_count  <= '0;
      end else begin
         x_min_q <= x_min_n;
         x_max_q <= x_max_n;
         y_min_q <= y_min_n;
         y_max_q <= y_max_n;
         cnt_q   <= cnt_n;

         // Publish at the last pixel, all zero when nothing matched
         if (frame_last) begin
            bbox_x_min <= (cnt_n == '0) ? '0 : x_min_n;
            bbox_x_max <= (cnt_n == '0) ? '0 : x_max_n;
            bbox_y_min <= (cnt_n == '0) ? '0 : y_min_n;
            bbox_y_max <= (cnt_n == '0) ? '0 : y_max_n;
            hit_count  <= cnt_n;
         end
      end
   end

endmodule

`default_nettype wire

/* logic/frame_capture.sv */
// Frame capture control
`timescale 1ns/100ps
`default_nettype none

module frame_capture #(
   parameter  int IMG_WIDTH  = 16,
   parameter  int IMG_HEIGHT = 12,
   localparam int ADDR_W     = $clog2(IMG_WIDTH * IMG_HEIGHT)
) (
   input  wire                         clock_50,
   input  wire                         arst_n,
   input  wire                         capture_start,
   input  wire                         thr_valid,
   input  wire                         thr_hit,
   input  wire vsense_pkg::pix_word_t  thr_pixel,
   output logic                        capture_busy,
   output logic                        wr_en,
   output logic [ADDR_W-1:0]           wr_addr,
   output vsense_pkg::pix_word_t       wr_data,
   output logic                        hit_valid,
   output logic                        frame_first,
   output logic                        frame_last,
   output logic                        frame_done,
   output vsense_pkg::coord_t          hit_x,
   output vsense_pkg::coord_t          hit_y,
   output logic [vsense_pkg::CNT_W-1:0] frame_count
);

   localparam vsense_pkg::coord_t X_LAST = vsense_pkg::coord_t'(IMG_WIDTH - 1);
   localparam vsense_pkg::coord_t Y_LAST = vsense_pkg::coord_t'(IMG_HEIGHT - 1);

   vsense_pkg::capture_state_e cap_state;
   vsense_pkg::coord_t         x_cnt;
   vsense_pkg::coord_t         y_cnt;
   logic [ADDR_W-1:0]          addr_cnt;
   logic                       accept;
   logic                       last_pix;

   assign accept       = thr_valid && (cap_state != vsense_pkg::CAP_IDLE);
   assign last_pix     = (x_cnt == X_LAST) && (y_cnt == Y_LAST);
   assign capture_busy = (cap_state != vsense_pkg::CAP_IDLE);

   // ------------------------------------------------------------
   // State machine and raster position
   // ------------------------------------------------------------
   always_ff @(posedge clock_50 or negedge arst_n) begin
      if (!arst_n) begin
         cap_state <= vsense_pkg::CAP_IDLE;
         x_cnt     <= '0;
         y_cnt     <= '0;
         addr_cnt  <= '0;
      end else begin
         case (cap_state)
            vsense_pkg::CAP_IDLE: begin
               if (capture_start) begin   // Catches the pixel in the threshold stage
                  cap_state <= vsense_pkg::CAP_ARMED;
                  x_cnt     <= '0;
                  y_cnt     <= '0;
                  addr_cnt  <= '0;
               end
            end
            vsense_pkg::CAP_ARMED, vsense_pkg::CAP_RUN: begin
               if (accept) begin
                  cap_state <= last_pix ? vsense_pkg::CAP_IDLE : vsense_pkg::CAP_RUN;
                  addr_cnt  <= addr_cnt + 1'b1;
                  if (x_cnt == X_LAST) begin   // End of line
                     x_cnt <= '0;
                     y_cnt <= y_cnt + 1'b1;
                  end else begin
                     x_cnt <= x_cnt + 1'b1;
                  end
               end
            end
            default: cap_state <= vsense_pkg::CAP_IDLE;
         endcase
      end
   end

   // ------------------------------------------------------------
   // Write strobes, frame markers and frame counter
   // ------------------------------------------------------------
   always_ff @(posedge clock_50 or negedge arst_n) begin
      if (!arst_n) begin
         wr_en       <= 1'b0;
         hit_valid   <= 1'b0;
         frame_first <= 1'b0;
         frame_last  <= 1'b0;
         frame_done  <= 1'b0;
         frame_count <= '0;
      end else begin
         wr_en       <= accept;
         hit_valid   <= accept && thr_hit;
         frame_first <= accept && (cap_state == vsense_pkg::CAP_ARMED);
         frame_last  <= accept && last_pix;
         frame_done  <= frame_last;   // One cycle after the last write
         if (frame_last) begin
            frame_count <= frame_count + 1'b1;
         end
      end
   end

   always_ff @(posedge clock_50) begin
      if (accept) begin
         wr_addr <= addr_cnt;
         wr_data <= thr_pixel;
         hit_x   <= x_cnt;
         hit_y   <= y_cnt;
      end
   end

   // Only the last pixel of a frame is written after the return to idle
   assert property (@(posedge clock_50) disable iff (!arst_n)
      wr_en && (cap_state == vsense_pkg::CAP_IDLE)
      |-> (wr_addr == ADDR_W'(IMG_WIDTH * IMG_HEIGHT - 1)));

endmodule

`default_nettype wire

/* logic/color_threshold.sv */
// Colour window threshold stage
`timescale 1ns/100ps
`default_nettype none

module color_threshold (
   input  wire                        clock_50,
   input  wire                        arst_n,
   input  wire                        pixel_valid,
   input  wire vsense_pkg::chan_t     pixel_red,
   input  wire vsense_pkg::chan_t     pixel_green,
   input  wire vsense_pkg::chan_t     pixel_blue,
   input  wire vsense_pkg::chan_t     red_min,
   input  wire vsense_pkg::chan_t     red_max,
   input  wire vsense_pkg::chan_t     green_min,
   input  wire vsense_pkg::chan_t     green_max,
   input  wire vsense_pkg::chan_t     blue_min,
   input  wire vsense_pkg::chan_t     blue_max,
   output logic                       thr_valid,
   output vsense_pkg::pix_word_t      thr_pixel,
   output logic                       thr_hit
);

   logic red_in;
   logic green_in;
   logic blue_in;

   // Inclusive window on each channel
   assign red_in   = (pixel_red >= red_min) && (pixel_red <= red_max);
   assign green_in = (pixel_green >= green_min) && (pixel_green <= green_max);
   assign blue_in  = (pixel_blue >= blue_min) && (pixel_blue <= blue_max);

   always_ff @(posedge clock_50 or negedge arst_n) begin
      if (!arst_n) begin
         thr_valid <= 1'b0;
         thr_hit   <= 1'b0;
      end else begin
         thr_valid <= pixel_valid;
         thr_hit   <= pixel_valid && red_in && green_in && blue_in;   // All three match
      end
   end

   always_ff @(posedge clock_50) begin
      if (pixel_valid) begin
         thr_pixel <= {pixel_red, pixel_green, pixel_blue};
      end
   end

   // Host must program a sane red window before pixels flow
   assert property (@(posedge clock_50) disable iff (!arst_n)
      pixel_valid |-> (red_min <= red_max));

endmodule

`default_nettype wire

/* logic/vsense_pkg.sv */
// Video sensor shared definitions
`default_nettype none

package vsense_pkg;

   // ------------------------------------------------------------
   // Widths
   // ------------------------------------------------------------
   localparam int CHAN_W  = 8;    // One colour channel
   localparam int COORD_W = 12;   // x or y position
   localparam int CNT_W   = 16;   // Hit and frame counters

   // ------------------------------------------------------------
   // Word types
   // ------------------------------------------------------------
   typedef logic [CHAN_W-1:0]  chan_t;
   typedef logic [COORD_W-1:0] coord_t;

   // Red in the top byte, then green, blue at the bottom
   typedef logic [3*CHAN_W-1:0] pix_word_t;

   // ------------------------------------------------------------
   // Enums
   // ------------------------------------------------------------
   typedef enum logic [1:0] {
      CAP_IDLE  = 2'd0,   // Waiting for capture_start
      CAP_ARMED = 2'd1,   // Next pixel is (0,0)
      CAP_RUN   = 2'd2    // Mid frame
   } capture_state_e;

   // Frame memory owner in a given cycle
   typedef enum logic [1:0] {
      OWN_NONE  = 2'd0,
      OWN_WRITE = 2'd1,   // Capture writer
      OWN_READ  = 2'd2    // Host read port
   } mem_owner_e;

endpackage

`default_nettype wire
